/* include/conv_fetch_config.svh */
`ifndef CONV_FETCH_CONFIG_SVH
`define CONV_FETCH_CONFIG_SVH

// pixels held by one buffer word
`define PIXELS_IN_ROW 32
// pixel index and width size
`define IDX_W 16
// descriptor queue entries
`define SEG_FIFO_DEPTH 4

// wishbone word address map
`define WB_ADDR_W 4
`define REG_IX 4'h0
`define REG_OX 4'h1
`define REG_POX 4'h2
// k in [3:0], s in [7:4], p in [11:8]
`define REG_KSP 4'h3
`define REG_CTRL 4'h4
`define REG_STATUS 4'h5
`define REG_COUNT 4'h6

`endif

/* source/conv_fetch_pkg.sv */
`include "conv_fetch_config.svh"

package conv_fetch_pkg;

   // pixel index, column count or width
   typedef logic [`IDX_W-1:0] idx_t;
   // kernel, stride, pad and pad counts
   typedef logic [3:0] small_t;

   // one layer as the host sets it up
   typedef struct packed {
      idx_t   ix;
      idx_t   ox;
      idx_t   pox;
      small_t k;
      small_t s;
      small_t p;
   } layer_cfg_t;

   // one kernel-row pass of one output tile
   typedef struct packed {
      idx_t ox_start;
      logic last;
   } pass_cmd_t;

   // one buffer word worth of input row
   typedef struct packed {
      idx_t   row_start_idx;
      idx_t   row_end_idx;
      idx_t   reg_start_idx;
      idx_t   reg_end_idx;
      small_t west_pad;
      small_t slab_num;
      small_t east_pad;
      logic   pass_end;
   } segment_t;

   // tile sequencer states
   typedef enum logic [1:0] {IDLE, RUN, DRAIN} seq_state_t;

endpackage

/* source/conv_cfg_decode.sv */
`include "conv_fetch_config.svh"

module conv_cfg_decode (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [`WB_ADDR_W-1:0]      wb_adr,
   input  logic [31:0]                wb_dat_w,
   input  logic [3:0]                 wb_sel,
   output logic [31:0]                wb_dat_r,
   output logic                       wb_ack,
   input  logic                       busy,
   input  conv_fetch_pkg::idx_t       seg_count,
   input  logic                       queue_empty,
   output conv_fetch_pkg::layer_cfg_t cfg,
   output logic                       start
);

   logic req;
   logic wr;
   logic s_ok;
   logic ctrl_go;
   logic done;
   logic error;
   logic job_active;

   ////////////////////////////////////////
   // wishbone classic handshake
   ////////////////////////////////////////

   // new access, ack follows next cycle
   assign req = wb_cyc && wb_stb && !wb_ack;
   // writes land on the ack cycle, full words only
   assign wr = wb_cyc && wb_stb && wb_we && wb_ack && (wb_sel == 4'hf);

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         // single-cycle ack, dropped even if stb stays up
         wb_ack <= req;
      end
   end

   // readback captured with the request
   always_ff @(posedge clk) begin
      if (req) begin
         case (wb_adr)
            `REG_IX:     wb_dat_r <= {{(32-`IDX_W){1'b0}}, cfg.ix};
            `REG_OX:     wb_dat_r <= {{(32-`IDX_W){1'b0}}, cfg.ox};
            `REG_POX:    wb_dat_r <= {{(32-`IDX_W){1'b0}}, cfg.pox};
            `REG_KSP:    wb_dat_r <= {20'd0, cfg.p, cfg.s, cfg.k};
            `REG_STATUS: wb_dat_r <= {29'd0, error, done, busy};
            `REG_COUNT:  wb_dat_r <= {{(32-`IDX_W){1'b0}}, seg_count};
            default:     wb_dat_r <= 32'd0;
         endcase
      end
   end

   ////////////////////////////////////////
   // layer registers
   ////////////////////////////////////////

   // layer is frozen while a job runs
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg <= '0;
      end else if (wr && !busy) begin
         case (wb_adr)
            `REG_IX:  cfg.ix <= wb_dat_w[`IDX_W-1:0];
            `REG_OX:  cfg.ox <= wb_dat_w[`IDX_W-1:0];
            `REG_POX: cfg.pox <= wb_dat_w[`IDX_W-1:0];
            `REG_KSP: begin
               cfg.k <= wb_dat_w[3:0];
               cfg.s <= wb_dat_w[7:4];
               cfg.p <= wb_dat_w[11:8];
            end
            default: ;
         endcase
      end
   end

   // only stride 1 and 2 are walked
   assign s_ok = (cfg.s == 4'd1) || (cfg.s == 4'd2);
   assign ctrl_go = wr && (wb_adr == `REG_CTRL) && wb_dat_w[0] && !busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         start <= 1'b0;
         error <= 1'b0;
      end else begin
         start <= ctrl_go && s_ok;
         // error sticks until the next start request
         if (ctrl_go) begin
            error <= !s_ok;
         end
      end
   end

   // done once the sequencer is idle and the queue has drained
   always_ff @(posedge clk) begin
      if (reset) begin
         done <= 1'b0;
         job_active <= 1'b0;
      end else if (start) begin
         done <= 1'b0;
         job_active <= 1'b1;
      end else if (job_active && !busy && queue_empty) begin
         done <= 1'b1;
         job_active <= 1'b0;
      end
   end

endmodule

/* source/conv_tile_sequencer.sv */
module conv_tile_sequencer (
   input  logic                       clk,
   input  logic                       reset,
   input  conv_fetch_pkg::layer_cfg_t cfg,
   input  logic                       start,
   input  logic                       pass_end,
   output logic                       en,
   output conv_fetch_pkg::pass_cmd_t  cur_pass,
   output conv_fetch_pkg::pass_cmd_t  next_pass,
   output logic                       tiling_end,
   output logic                       busy
);
   import conv_fetch_pkg::*;

   seq_state_t state;
   idx_t       ox_start;
   small_t     krow;
   small_t     k_last;
   logic       last_krow;
   idx_t       nxt_ox_start;
   small_t     nxt_krow;

   assign k_last = cfg.k - 4'd1;
   assign last_krow = (krow == k_last);

   // after the last kernel row the tile moves on by pox
   assign nxt_ox_start = last_krow ? ox_start + cfg.pox : ox_start;
   assign nxt_krow = last_krow ? 4'd0 : krow + 4'd1;

   // final pass is the last kernel row of the tile reaching past ox
   assign cur_pass.ox_start = ox_start;
   assign cur_pass.last = last_krow && (ox_start + cfg.pox > cfg.ox);

   // lookahead for the walker's register preload
   assign next_pass.ox_start = nxt_ox_start;
   assign next_pass.last = (nxt_krow == k_last) && (nxt_ox_start + cfg.pox > cfg.ox);

   assign tiling_end = (state == RUN) && cur_pass.last;
   assign busy = (state != IDLE);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
         en <= 1'b0;
         ox_start <= 16'd1;
         krow <= 4'd0;
      end else begin
         en <= 1'b0;
         case (state)
            IDLE: begin
               if (start) begin
                  state <= RUN;
                  en <= 1'b1;
                  ox_start <= 16'd1;
                  krow <= 4'd0;
               end
            end
            RUN: begin
               if (pass_end) begin
                  if (cur_pass.last) begin
                     state <= DRAIN;
                  end else begin
                     ox_start <= nxt_ox_start;
                     krow <= nxt_krow;
                  end
               end
            end
            // one cycle so the last descriptor reaches the queue
            DRAIN: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* source/conv_row_walker.sv */
`include "conv_fetch_config.svh"

module conv_row_walker (
   input  logic                       clk,
   input  logic                       reset,
   input  conv_fetch_pkg::layer_cfg_t cfg,
   input  logic                       en,
   input  conv_fetch_pkg::pass_cmd_t  cur_pass,
   input  conv_fetch_pkg::pass_cmd_t  next_pass,
   input  logic                       tiling_end,
   input  logic                       q_stall,
   output conv_fetch_pkg::segment_t   wseg,
   output logic                       wseg_valid,
   output logic                       pass_end
);
   import conv_fetch_pkg::*;

   localparam int unsigned PIX = `PIXELS_IN_ROW;

   idx_t   ix_start;
   idx_t   ix_end;
   idx_t   p_plus_1;
   idx_t   p_plus_ix;
   small_t left_pad;
   small_t right_pad;
   small_t overlap;
   small_t east_pad;
   idx_t   row_start_fix;
   idx_t   row_end;
   idx_t   row_end_up;
   idx_t   row_end_fix;
   idx_t   row_start;
   idx_t   adr;
   idx_t   reg_from;
   idx_t   reg_to;
   logic   active;
   logic   stall;
   logic   go;
   logic   seg_last;
   small_t seg_cnt;
   small_t stall_cnt;

   // first input column, (ox_start-1)*s+1
   function automatic idx_t first_col(input idx_t ox, input small_t s);
      return (s == 4'd2) ? (ox << 1) - 16'd1 : ox;
   endfunction

   // pad columns in front of the row
   function automatic small_t left_pad_of(input idx_t col, input small_t p);
      return (col <= idx_t'(p)) ? small_t'(idx_t'(p) - col + 16'd1) : 4'd0;
   endfunction

   // columns shared with the previous tile
   function automatic small_t overlap_of(input idx_t col, input small_t p);
      return (col <= idx_t'(p) + 16'd1) ? 4'd0 : p;
   endfunction

   // register slot of the first real pixel
   function automatic idx_t reg_init_of(input idx_t col, input small_t p);
      return idx_t'(left_pad_of(col, p)) + idx_t'(overlap_of(col, p)) + 16'd1;
   endfunction

   ////////////////////////////////////////
   // pass geometry
   ////////////////////////////////////////

   assign ix_start = first_col(cur_pass.ox_start, cfg.s);
   // last column, ix_start + (pox-1)*s + k-1
   assign ix_end = ix_start + cfg.pox + idx_t'(cfg.k) - 16'd2
                 + ((cfg.s == 4'd2) ? cfg.pox - 16'd1 : 16'd0);
   assign p_plus_1 = idx_t'(cfg.p) + 16'd1;
   assign p_plus_ix = idx_t'(cfg.p) + cfg.ix;

   assign left_pad = left_pad_of(ix_start, cfg.p);
   assign overlap = overlap_of(ix_start, cfg.p);
   // pad columns past the right edge of the row
   assign right_pad = (ix_end > p_plus_ix) ? small_t'(ix_end - p_plus_ix) : 4'd0;

   // zero-based memory columns
   assign row_start_fix = ix_start + idx_t'(left_pad) - p_plus_1 + idx_t'(overlap);
   assign row_end = ix_end - idx_t'(right_pad) - p_plus_1;
   // round up to the end of a buffer word, clip at ix-1
   assign row_end_up = row_end | idx_t'(PIX - 1);
   assign row_end_fix = (row_end_up > cfg.ix - 16'd1) ? cfg.ix - 16'd1 : row_end_up;

   ////////////////////////////////////////
   // word loop
   ////////////////////////////////////////

   assign row_start = row_start_fix + adr;
   // short last word only advances to the real row end
   assign reg_to = (row_start + idx_t'(PIX - 1) > row_end) ?
                   reg_from + row_end - row_start :
                   reg_from + idx_t'(PIX - 1);

   assign stall = (stall_cnt != 4'd0) || q_stall;
   assign go = active && !stall;
   assign seg_last = go && (adr + idx_t'(PIX) > row_end_fix - row_start_fix);

   always_ff @(posedge clk) begin
      if (reset) begin
         active <= 1'b0;
      end else if (en) begin
         active <= 1'b1;
      end else if (seg_last && tiling_end) begin
         active <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         adr <= '0;
         reg_from <= '0;
      end else if (en) begin
         adr <= '0;
         reg_from <= reg_init_of(ix_start, cfg.p);
      end else if (seg_last) begin
         // preload for the pass the sequencer switches to
         adr <= '0;
         reg_from <= reg_init_of(first_col(next_pass.ox_start, cfg.s), cfg.p);
      end else if (go) begin
         adr <= adr + idx_t'(PIX);
         reg_from <= reg_to + 16'd1;
      end
   end

   // segments in the running pass, saturating
   always_ff @(posedge clk) begin
      if (reset) begin
         seg_cnt <= 4'd1;
      end else if (en || seg_last) begin
         seg_cnt <= 4'd1;
      end else if (go && seg_cnt != 4'hf) begin
         seg_cnt <= seg_cnt + 4'd1;
      end
   end

   // kernel-row stall
   // short passes are stretched to k cycles, except the final one
   always_ff @(posedge clk) begin
      if (reset) begin
         stall_cnt <= 4'd0;
      end else if (en) begin
         stall_cnt <= 4'd0;
      end else if (seg_last) begin
         stall_cnt <= (!tiling_end && seg_cnt < cfg.k) ? cfg.k - seg_cnt : 4'd0;
      end else if (stall_cnt != 4'd0) begin
         stall_cnt <= stall_cnt - 4'd1;
      end
   end

   ////////////////////////////////////////
   // descriptor out
   ////////////////////////////////////////

   assign east_pad = seg_last ? right_pad : 4'd0;

   assign wseg.row_start_idx = row_start;
   assign wseg.row_end_idx = row_start + idx_t'(PIX - 1);
   assign wseg.reg_start_idx = reg_from;
   assign wseg.reg_end_idx = reg_to + idx_t'(east_pad);
   // front pads only on the first word of the pass
   assign wseg.west_pad = (adr == '0) ? left_pad : 4'd0;
   assign wseg.slab_num = (adr == '0) ? overlap : 4'd0;
   assign wseg.east_pad = east_pad;
   assign wseg.pass_end = seg_last;

   assign wseg_valid = go;
   assign pass_end = seg_last;

endmodule

/* source/conv_segment_result.sv */
`include "conv_fetch_config.svh"

module conv_segment_result (
   input  logic                     clk,
   input  logic                     reset,
   input  conv_fetch_pkg::segment_t wseg,
   input  logic                     wseg_valid,
   output conv_fetch_pkg::segment_t seg,
   output logic                     seg_valid,
   input  logic                     seg_ready,
   output logic                     q_stall,
   output logic                     queue_empty,
   output conv_fetch_pkg::idx_t     seg_count
);
   import conv_fetch_pkg::*;

   localparam int unsigned DEPTH = `SEG_FIFO_DEPTH;
   localparam int unsigned PTR_W = $clog2(DEPTH);
   // longer than any kernel-row gap inside one job
   localparam int unsigned IDLE_CYCLES = 16;
   localparam int unsigned IDLE_W = $clog2(IDLE_CYCLES) + 1;

   segment_t          mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W:0]    count;
   logic [IDLE_W-1:0] idle_cnt;
   logic              idle;
   logic              rd;

   assign rd = seg_valid && seg_ready;
   assign seg_valid = (count != '0);
   assign queue_empty = (count == '0);
   assign seg = mem[rd_ptr];
   // walker holds off with one slot still free
   assign q_stall = (count >= (PTR_W + 1)'(DEPTH - 1));
   assign idle = (idle_cnt == IDLE_W'(IDLE_CYCLES));

   always_ff @(posedge clk) begin
      if (wseg_valid) begin
         mem[wr_ptr] <= wseg;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (wseg_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + (PTR_W + 1)'(wseg_valid) - (PTR_W + 1)'(rd);
      end
   end

   // empty-queue age, saturating
   always_ff @(posedge clk) begin
      if (reset) begin
         idle_cnt <= IDLE_W'(IDLE_CYCLES);
      end else if (!queue_empty || wseg_valid) begin
         idle_cnt <= '0;
      end else if (!idle) begin
         idle_cnt <= idle_cnt + 1'b1;
      end
   end

   // delivered count restarts with the first descriptor of a job
   always_ff @(posedge clk) begin
      if (reset) begin
         seg_count <= '0;
      end else if (wseg_valid && idle) begin
         seg_count <= '0;
      end else if (rd) begin
         seg_count <= seg_count + 16'd1;
      end
   end

endmodule

/* source/conv_fetch_top.sv */
`include "conv_fetch_config.svh"

module conv_fetch_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [`WB_ADDR_W-1:0]    wb_adr,
   input  logic [31:0]              wb_dat_w,
   input  logic [3:0]               wb_sel,
   output logic [31:0]              wb_dat_r,
   output logic                     wb_ack,
   output conv_fetch_pkg::segment_t seg,
   output logic                     seg_valid,
   input  logic                     seg_ready
);
   import conv_fetch_pkg::*;

   layer_cfg_t cfg;
   logic       start;
   logic       busy;
   logic       en;
   pass_cmd_t  cur_pass;
   pass_cmd_t  next_pass;
   logic       tiling_end;
   logic       pass_end;
   segment_t   wseg;
   logic       wseg_valid;
   logic       q_stall;
   logic       queue_empty;
   idx_t       seg_count;

   // host registers
   conv_cfg_decode i_conv_cfg_decode (
      .clk         (clk),
      .reset       (reset),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_sel      (wb_sel),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .busy        (busy),
      .seg_count   (seg_count),
      .queue_empty (queue_empty),
      .cfg         (cfg),
      .start       (start)
   );

   // tiles and kernel rows
   conv_tile_sequencer i_conv_tile_sequencer (
      .clk        (clk),
      .reset      (reset),
      .cfg        (cfg),
      .start      (start),
      .pass_end   (pass_end),
      .en         (en),
      .cur_pass   (cur_pass),
      .next_pass  (next_pass),
      .tiling_end (tiling_end),
      .busy       (busy)
   );

   // word-by-word segments of each pass
   conv_row_walker i_conv_row_walker (
      .clk        (clk),
      .reset      (reset),
      .cfg        (cfg),
      .en         (en),
      .cur_pass   (cur_pass),
      .next_pass  (next_pass),
      .tiling_end (tiling_end),
      .q_stall    (q_stall),
      .wseg       (wseg),
      .wseg_valid (wseg_valid),
      .pass_end   (pass_end)
   );

   // descriptor queue onto the stream
   conv_segment_result i_conv_segment_result (
      .clk         (clk),
      .reset       (reset),
      .wseg        (wseg),
      .wseg_valid  (wseg_valid),
      .seg         (seg),
      .seg_valid   (seg_valid),
      .seg_ready   (seg_ready),
      .q_stall     (q_stall),
      .queue_empty (queue_empty),
      .seg_count   (seg_count)
   );

endmodule

/* sim/conv_fetch_chk.sv */
`include "conv_fetch_config.svh"

module conv_fetch_chk (
   input logic                     clk,
   input logic                     reset,
   input logic                     start,
   input logic                     done,
   input conv_fetch_pkg::small_t   p,
   input conv_fetch_pkg::segment_t seg,
   input logic                     seg_valid,
   input logic                     seg_ready
);
   import conv_fetch_pkg::*;

   logic        xfer;
   logic        first_of_pass;
   logic        first_of_job;
   segment_t    prev;
   int unsigned fail_count = 0;

   // one descriptor leaves the queue
   assign xfer = seg_valid && seg_ready;

   // last delivered descriptor and pass/job position
   always_ff @(posedge clk) begin
      if (reset) begin
         prev <= '0;
         first_of_pass <= 1'b1;
         first_of_job <= 1'b0;
      end else begin
         if (xfer) begin
            prev <= seg;
            first_of_pass <= seg.pass_end;
         end
         if (start) begin
            first_of_job <= 1'b1;
         end else if (xfer) begin
            first_of_job <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // segment shape
   ////////////////////////////////////////

   a_row_width: assert property (@(posedge clk) disable iff (reset)
      xfer |-> seg.row_end_idx == seg.row_start_idx + idx_t'(`PIXELS_IN_ROW - 1))
   else begin
      $error("row end is not one buffer word past row start");
      fail_count++;
   end

   // next word of the same pass
   a_row_step: assert property (@(posedge clk) disable iff (reset)
      xfer && !first_of_pass |-> seg.row_start_idx == prev.row_start_idx
                                                  + idx_t'(`PIXELS_IN_ROW))
   else begin
      $error("row start did not advance by one buffer word");
      fail_count++;
   end

   // register file indices run on
   a_reg_step: assert property (@(posedge clk) disable iff (reset)
      xfer && !first_of_pass |-> seg.reg_start_idx == prev.reg_end_idx + idx_t'(1))
   else begin
      $error("register start does not follow previous register end");
      fail_count++;
   end

   ////////////////////////////////////////
   // padding placement
   ////////////////////////////////////////

   a_front_pads: assert property (@(posedge clk) disable iff (reset)
      xfer && !first_of_pass |-> seg.west_pad == '0 && seg.slab_num == '0)
   else begin
      $error("west pad or slab count past the first segment of a pass");
      fail_count++;
   end

   a_east_pad: assert property (@(posedge clk) disable iff (reset)
      xfer && !seg.pass_end |-> seg.east_pad == '0)
   else begin
      $error("east pad on a segment without pass end");
      fail_count++;
   end

   // left edge of the first tile
   a_first_west: assert property (@(posedge clk) disable iff (reset)
      xfer && first_of_job |-> seg.west_pad == p)
   else begin
      $error("first segment of the job lacks the layer padding");
      fail_count++;
   end

   ////////////////////////////////////////
   // stream rules
   ////////////////////////////////////////

   a_hold: assert property (@(posedge clk) disable iff (reset)
      seg_valid && !seg_ready |=> seg_valid && $stable(seg))
   else begin
      $error("descriptor dropped or changed while stalled");
      fail_count++;
   end

   a_quiet_after_done: assert property (@(posedge clk) disable iff (reset)
      done |-> !seg_valid)
   else begin
      $error("descriptor offered after done");
      fail_count++;
   end

endmodule

bind conv_fetch_top conv_fetch_chk i_conv_fetch_chk (
   .clk       (clk),
   .reset     (reset),
   .start     (start),
   .done      (i_conv_cfg_decode.done),
   .p         (cfg.p),
   .seg       (seg),
   .seg_valid (seg_valid),
   .seg_ready (seg_ready)
);

/* sim/conv_fetch_tb.sv */
`include "conv_fetch_config.svh"

module conv_fetch_tb;
   import conv_fetch_pkg::*;

   // ack cycles per access, status polls per job
   localparam int unsigned ACK_LIMIT = 20;
   localparam int unsigned DONE_POLLS = 400;

   logic                  clk;
   logic                  reset;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [`WB_ADDR_W-1:0] wb_adr;
   logic [31:0]           wb_dat_w;
   logic [3:0]            wb_sel;
   logic [31:0]           wb_dat_r;
   logic                  wb_ack;
   segment_t              seg;
   logic                  seg_valid;
   logic                  seg_ready;
   int unsigned           received = 0;
   int unsigned           pass_ends = 0;

   conv_fetch_top i_conv_fetch_top (
      .clk       (clk),
      .reset     (reset),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_sel    (wb_sel),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .seg       (seg),
      .seg_valid (seg_valid),
      .seg_ready (seg_ready)
   );

   always #10 clk = ~clk;

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         stop_run($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual));
      end
   endtask

   ////////////////////////////////////////
   // wishbone host
   ////////////////////////////////////////

   task automatic write_reg(input logic [`WB_ADDR_W-1:0] adr, input logic [31:0] data);
      int unsigned waited;
      waited = 0;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b1;
      wb_adr <= adr;
      wb_dat_w <= data;
      do begin
         @(posedge clk);
         waited++;
         if (waited > ACK_LIMIT) stop_run("no wishbone ack on a register write");
      end while (!wb_ack);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
   endtask

   task automatic read_reg(input logic [`WB_ADDR_W-1:0] adr, output logic [31:0] data);
      int unsigned waited;
      waited = 0;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b0;
      wb_adr <= adr;
      do begin
         @(posedge clk);
         waited++;
         if (waited > ACK_LIMIT) stop_run("no wishbone ack on a register read");
      end while (!wb_ack);
      data = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   ////////////////////////////////////////
   // test sequences
   ////////////////////////////////////////

   // stride 3 is refused, nothing streams out
   task automatic stride_error_test();
      logic [31:0] value;
      int unsigned rx_base;
      rx_base = received;
      write_reg(`REG_KSP, 32'h133);
      read_reg(`REG_KSP, value);
      check_value("KSP readback", 32'h133, value);
      write_reg(`REG_CTRL, 32'd1);
      read_reg(`REG_STATUS, value);
      check_value("STATUS error bit", 32'h4, value);
      repeat (30) @(posedge clk);
      check_value("descriptors for stride 3", 32'd0, received - rx_base);
   endtask

   task automatic run_layer(input idx_t ix, input idx_t ox, input idx_t pox,
                            input small_t k, input small_t s, input small_t p);
      logic [31:0] ksp;
      logic [31:0] value;
      int unsigned rx_base;
      int unsigned pe_base;
      int unsigned polls;
      int unsigned tiles;
      ksp = {20'd0, p, s, k};
      write_reg(`REG_IX, 32'(ix));
      write_reg(`REG_OX, 32'(ox));
      write_reg(`REG_POX, 32'(pox));
      write_reg(`REG_KSP, ksp);
      read_reg(`REG_IX, value);
      check_value("IX readback", 32'(ix), value);
      read_reg(`REG_OX, value);
      check_value("OX readback", 32'(ox), value);
      read_reg(`REG_POX, value);
      check_value("POX readback", 32'(pox), value);
      read_reg(`REG_KSP, value);
      check_value("KSP readback", ksp, value);
      rx_base = received;
      pe_base = pass_ends;
      write_reg(`REG_CTRL, 32'd1);
      // poll for done
      polls = 0;
      do begin
         read_reg(`REG_STATUS, value);
         polls++;
         if (polls > DONE_POLLS) stop_run("done bit never rose");
      end while (!value[1]);
      check_value("STATUS after run", 32'h2, value);
      read_reg(`REG_COUNT, value);
      check_value("COUNT vs received", received - rx_base, value);
      // k passes per output tile
      tiles = (32'(ox) + 32'(pox) - 1) / 32'(pox);
      check_value("pass_end descriptors", 32'(k) * tiles, pass_ends - pe_base);
   endtask

   // stream sink, ready at random
   initial begin
      void'($urandom(32'hf319));
      seg_ready = 1'b0;
      forever begin
         @(posedge clk);
         if (seg_valid && seg_ready) begin
            received <= received + 1;
            if (seg.pass_end) pass_ends <= pass_ends + 1;
         end
         seg_ready <= (($urandom & 32'h3) != 32'h0);
      end
   end

   // checker errors end the run at once
   always @(posedge clk) begin
      if (i_conv_fetch_top.i_conv_fetch_chk.fail_count != 0) begin
         stop_run("checker assertion failed");
      end
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = 32'd0;
      wb_sel = 4'hf;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      stride_error_test();
      run_layer(16'd64, 16'd62, 16'd16, 4'd3, 4'd1, 4'd1);
      run_layer(16'd64, 16'd32, 16'd8, 4'd3, 4'd2, 4'd1);
      repeat (2) @(posedge clk);
      if (i_conv_fetch_top.i_conv_fetch_chk.fail_count != 0) begin
         stop_run("checker assertion failed");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

/* conv_fetch.f */
+incdir+include
source/conv_fetch_pkg.sv
source/conv_cfg_decode.sv
source/conv_tile_sequencer.sv
source/conv_row_walker.sv
source/conv_segment_result.sv
source/conv_fetch_top.sv
sim/conv_fetch_chk.sv
sim/conv_fetch_tb.sv
